//--- Makefile
# Verilator build and run of the CHIP-8 core testbench

VERILATOR ?= verilator
TOP       ?= chip8_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/chip8_pkg.sv
// Shared widths, enums and instruction layout, imported by every CHIP-8 core block
package chip8_pkg;

	// Program address and data widths
	localparam int addr_w = 12;
	localparam int word_w = 8;

	// Return stack entries
	localparam int stack_depth = 16;

	typedef logic [addr_w-1:0] pc_t;
	typedef logic [word_w-1:0] byte_t;
	typedef logic [3:0]        reg_idx_t;

	// First fetch after reset, classic interpreter load address
	localparam pc_t start_addr = 12'h200;

	// VF holds carry, no-borrow and shifted-out bits
	localparam reg_idx_t flag_reg = 4'hF;

	// Top nibble of the instruction word
	typedef enum logic [3:0] {
		op_sys     = 4'h0,
		op_jp      = 4'h1,
		op_call    = 4'h2,
		op_se_imm  = 4'h3,
		op_sne_imm = 4'h4,
		op_se_reg  = 4'h5,
		op_ld_imm  = 4'h6,
		op_add_imm = 4'h7,
		op_alu     = 4'h8,
		op_sne_reg = 4'h9,
		op_jp_v0   = 4'hB
	} op_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_or,
		alu_and,
		alu_xor,
		alu_shr,
		alu_shl,
		alu_pass
	} alu_op_e;

	typedef enum logic [2:0] {
		pc_hold,
		pc_next,
		pc_skip,
		pc_jump,
		pc_ret
	} pc_sel_e;

	typedef enum logic [1:0] {
		stk_hold,
		stk_push,
		stk_pop
	} stack_op_e;

	// Three decodings of one instruction word
	typedef struct packed {
		op_e op;
		pc_t addr;
	} instr_nnn_t;

	typedef struct packed {
		op_e      op;
		reg_idx_t x;
		byte_t    kk;
	} instr_xkk_t;

	typedef struct packed {
		op_e        op;
		reg_idx_t   x;
		reg_idx_t   y;
		logic [3:0] n;
	} instr_xyn_t;

	typedef union packed {
		instr_nnn_t nnn;
		instr_xkk_t xkk;
		instr_xyn_t xyn;
	} instr_u;

endpackage

//--- common/chip8_reg_if.sv
// Register file access bundle, instantiated once in the core between control and V registers
`timescale 1ns/1ps
interface chip8_reg_if;
	import chip8_pkg::*;

	// Read addresses, rd_x is also the x write address
	reg_idx_t rd_x;
	reg_idx_t rd_y;

	// Combinational read data
	byte_t x_val;
	byte_t y_val;

	// Vx write port
	logic  wr_x_en;
	byte_t wr_x_data;

	// VF write port, wins over the x port on a clash
	logic  wr_f_en;
	byte_t wr_f_data;

	modport control (
		output rd_x, rd_y, wr_x_en, wr_x_data, wr_f_en, wr_f_data,
		input  x_val, y_val
	);

	modport register (
		input  rd_x, rd_y, wr_x_en, wr_x_data, wr_f_en, wr_f_data,
		output x_val, y_val
	);

endinterface

//--- design/chip8_alu.sv
// Eight-bit combinational ALU for the 8xy group, 7xkk and the Bnnn low byte
`timescale 1ns/1ps
module chip8_alu (
	input  chip8_pkg::alu_op_e alu_op,
	input  chip8_pkg::byte_t   alu_a,
	input  chip8_pkg::byte_t   alu_b,
	output chip8_pkg::byte_t   alu_res,
	output logic               alu_flag
);
	import chip8_pkg::*;

	logic [word_w:0] sum;

	// Carry comes out as the ninth bit
	assign sum = {1'b0, alu_a} + {1'b0, alu_b};

	always_comb begin
		alu_res  = alu_b;
		alu_flag = 1'b0;
		case (alu_op)
			alu_add: begin
				alu_res  = sum[word_w-1:0];
				alu_flag = sum[word_w];
			end
			alu_sub: begin
				// Flag is no-borrow
				alu_res  = alu_a - alu_b;
				alu_flag = (alu_a >= alu_b);
			end
			alu_or:  alu_res = alu_a | alu_b;
			alu_and: alu_res = alu_a & alu_b;
			alu_xor: alu_res = alu_a ^ alu_b;
			alu_shr: begin
				alu_res  = alu_a >> 1;
				alu_flag = alu_a[0];
			end
			alu_shl: begin
				alu_res  = alu_a << 1;
				alu_flag = alu_a[word_w-1];
			end
			default: begin
				// PASS hands b through
				alu_res  = alu_b;
				alu_flag = 1'b0;
			end
		endcase
	end

endmodule

//--- design/chip8_core.sv
// Top level of the CHIP-8 core with a Wishbone instruction port and register write-back pins
`timescale 1ns/1ps
module chip8_core #(
	parameter chip8_pkg::pc_t start_addr  = chip8_pkg::start_addr,
	parameter int             stack_depth = chip8_pkg::stack_depth
) (
	input  logic                cpu_clk,
	input  logic                arst_n,
	// Wishbone classic, read only
	output logic                wb_cyc,
	output logic                wb_stb,
	output chip8_pkg::pc_t      wb_adr,
	input  logic [15:0]         wb_dat_r,
	input  logic                wb_ack,
	// Register write-back, one cycle per write
	output logic                vx_we,
	output chip8_pkg::reg_idx_t vx_addr,
	output chip8_pkg::byte_t    vx_data,
	output logic                vf_we,
	output chip8_pkg::byte_t    vf_data
);
	import chip8_pkg::*;

	logic      fetch_start;
	logic      fetch_done;
	instr_u    instr;
	alu_op_e   alu_op;
	byte_t     alu_a;
	byte_t     alu_b;
	byte_t     alu_res;
	logic      alu_flag;
	pc_sel_e   pc_sel;
	stack_op_e stack_op;
	pc_t       jump_target;
	pc_t       pc;

	chip8_reg_if reg_if ();

	chip8_control u_control (
		.cpu_clk     (cpu_clk),
		.arst_n      (arst_n),
		.fetch_done  (fetch_done),
		.instr       (instr),
		.alu_res     (alu_res),
		.alu_flag    (alu_flag),
		.pc          (pc),
		.fetch_start (fetch_start),
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.pc_sel      (pc_sel),
		.stack_op    (stack_op),
		.jump_target (jump_target),
		.regs        (reg_if)
	);

	chip8_fetch u_fetch (
		.cpu_clk     (cpu_clk),
		.arst_n      (arst_n),
		.fetch_start (fetch_start),
		.pc          (pc),
		.wb_ack      (wb_ack),
		.wb_dat_r    (wb_dat_r),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_adr      (wb_adr),
		.fetch_done  (fetch_done),
		.instr       (instr)
	);

	chip8_alu u_alu (
		.alu_op   (alu_op),
		.alu_a    (alu_a),
		.alu_b    (alu_b),
		.alu_res  (alu_res),
		.alu_flag (alu_flag)
	);

	chip8_regfile u_regfile (
		.cpu_clk (cpu_clk),
		.arst_n  (arst_n),
		.regs    (reg_if)
	);

	chip8_pc_stack #(
		.start_addr  (start_addr),
		.stack_depth (stack_depth)
	) u_pc_stack (
		.cpu_clk     (cpu_clk),
		.arst_n      (arst_n),
		.pc_sel      (pc_sel),
		.stack_op    (stack_op),
		.jump_target (jump_target),
		.pc          (pc)
	);

	// Write-back pins mirror the register file write ports
	assign vx_we   = reg_if.wr_x_en;
	assign vx_addr = reg_if.rd_x;
	assign vx_data = reg_if.wr_x_data;
	assign vf_we   = reg_if.wr_f_en;
	assign vf_data = reg_if.wr_f_data;

endmodule

//--- design/chip8_fetch.sv
// Wishbone classic read master fetching one instruction word per fetch_start request
`timescale 1ns/1ps
module chip8_fetch (
	input  logic              cpu_clk,
	input  logic              arst_n,
	input  logic              fetch_start,
	input  chip8_pkg::pc_t    pc,
	input  logic              wb_ack,
	input  logic [15:0]       wb_dat_r,
	output logic              wb_cyc,
	output logic              wb_stb,
	output chip8_pkg::pc_t    wb_adr,
	output logic              fetch_done,
	output chip8_pkg::instr_u instr
);
	import chip8_pkg::*;

	logic req;

	// Request held from fetch_start until ack, then dropped for at least a cycle
	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			req        <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			if (req) begin
				if (wb_ack) begin
					req        <= 1'b0;
					fetch_done <= 1'b1;
				end
			end else if (fetch_start) begin
				req <= 1'b1;
			end
		end
	end

	// Instruction word captured on the acked cycle
	always_ff @(posedge cpu_clk) begin
		if (req && wb_ack) begin
			instr <= wb_dat_r;
		end
	end

	assign wb_cyc = req;
	assign wb_stb = req;

	// PC only moves at the end of EXEC, so the address is stable for the whole cycle
	assign wb_adr = pc;

endmodule

//--- design/chip8_pc_stack.sv
// Program counter and return stack, updated at the edge that closes each EXEC cycle
`timescale 1ns/1ps
module chip8_pc_stack #(
	parameter chip8_pkg::pc_t start_addr  = chip8_pkg::start_addr,
	parameter int             stack_depth = chip8_pkg::stack_depth
) (
	input  logic                 cpu_clk,
	input  logic                 arst_n,
	input  chip8_pkg::pc_sel_e   pc_sel,
	input  chip8_pkg::stack_op_e stack_op,
	input  chip8_pkg::pc_t       jump_target,
	output chip8_pkg::pc_t       pc
);
	import chip8_pkg::*;

	localparam int sp_w = $clog2(stack_depth);

	pc_t             stack [stack_depth];
	logic [sp_w-1:0] sp;
	logic [sp_w-1:0] sp_inc;
	logic [sp_w-1:0] sp_dec;
	pc_t             pc_inc2;

	// sp is the next free slot, top of stack sits one below
	assign sp_inc  = (sp == sp_w'(stack_depth - 1)) ? '0 : sp + 1'b1;
	assign sp_dec  = (sp == '0) ? sp_w'(stack_depth - 1) : sp - 1'b1;
	assign pc_inc2 = pc + pc_t'(2);

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= start_addr;
			sp <= '0;
		end else begin
			// All PC steps wrap at 12 bits
			case (pc_sel)
				pc_next: pc <= pc_inc2;
				pc_skip: pc <= pc + pc_t'(4);
				pc_jump: pc <= jump_target;
				pc_ret:  pc <= stack[sp_dec];
				default: pc <= pc;
			endcase
			case (stack_op)
				stk_push: sp <= sp_inc;
				stk_pop:  sp <= sp_dec;
				default:  sp <= sp;
			endcase
		end
	end

	// Return address of a CALL
	always_ff @(posedge cpu_clk) begin
		if (stack_op == stk_push) begin
			stack[sp] <= pc_inc2;
		end
	end

endmodule

//--- design/chip8_regfile.sv
// Sixteen V registers with two combinational reads, an x write port and a priority VF port
`timescale 1ns/1ps
module chip8_regfile (
	input  logic          cpu_clk,
	input  logic          arst_n,
	chip8_reg_if.register regs
);
	import chip8_pkg::*;

	byte_t v [16];

	// VF port goes last so it wins when x is F
	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			v <= '{default: '0};
		end else begin
			if (regs.wr_x_en) begin
				v[regs.rd_x] <= regs.wr_x_data;
			end
			if (regs.wr_f_en) begin
				v[flag_reg] <= regs.wr_f_data;
			end
		end
	end

	// Reads see the old value within EXEC
	assign regs.x_val = v[regs.rd_x];
	assign regs.y_val = v[regs.rd_y];

endmodule

//--- design/control/chip8_control.sv
// Fetch/execute sequencer and instruction decoder steering ALU, registers and PC each EXEC cycle
`timescale 1ns/1ps
module chip8_control (
	input  logic                 cpu_clk,
	input  logic                 arst_n,
	input  logic                 fetch_done,
	input  chip8_pkg::instr_u    instr,
	input  chip8_pkg::byte_t     alu_res,
	input  logic                 alu_flag,
	input  chip8_pkg::pc_t       pc,
	output logic                 fetch_start,
	output chip8_pkg::alu_op_e   alu_op,
	output chip8_pkg::byte_t     alu_a,
	output chip8_pkg::byte_t     alu_b,
	output chip8_pkg::pc_sel_e   pc_sel,
	output chip8_pkg::stack_op_e stack_op,
	output chip8_pkg::pc_t       jump_target,
	chip8_reg_if.control         regs
);
	import chip8_pkg::*;

	typedef enum logic [1:0] {
		st_reset,
		st_fetch,
		st_exec
	} state_e;

	state_e state_q;
	state_e state;
	logic   wr_x;
	logic   flag_op;

	// EXEC is the cycle in which fetch_done pulses, so it is not held in the register
	always_comb begin
		state = state_q;
		if (state_q == st_fetch && fetch_done) begin
			state = st_exec;
		end
	end

	// Both RESET and EXEC hand over to a fresh fetch
	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_reset;
		end else begin
			state_q <= st_fetch;
		end
	end

	always_comb begin
		fetch_start = (state != st_fetch);
		alu_op      = alu_pass;
		alu_a       = regs.x_val;
		alu_b       = regs.y_val;
		pc_sel      = pc_hold;
		stack_op    = stk_hold;
		// Idle target is the current PC
		jump_target = pc;
		regs.rd_x   = instr.xyn.x;
		regs.rd_y   = instr.xyn.y;
		wr_x        = 1'b0;
		flag_op     = 1'b0;
		if (state == st_exec) begin
			// Unlisted words fall through as no-ops
			pc_sel = pc_next;
			case (instr.nnn.op)
				op_sys: begin
					// Only 00EE is kept from the 0nnn group
					if (instr.nnn.addr == 12'h0EE) begin
						pc_sel   = pc_ret;
						stack_op = stk_pop;
					end
				end
				op_jp: begin
					pc_sel      = pc_jump;
					jump_target = instr.nnn.addr;
				end
				op_call: begin
					pc_sel      = pc_jump;
					stack_op    = stk_push;
					jump_target = instr.nnn.addr;
				end
				op_se_imm: begin
					pc_sel = (regs.x_val == instr.xkk.kk) ? pc_skip : pc_next;
				end
				op_sne_imm: begin
					pc_sel = (regs.x_val != instr.xkk.kk) ? pc_skip : pc_next;
				end
				op_se_reg: begin
					if (instr.xyn.n == 4'h0 && regs.x_val == regs.y_val) begin
						pc_sel = pc_skip;
					end
				end
				op_sne_reg: begin
					if (instr.xyn.n == 4'h0 && regs.x_val != regs.y_val) begin
						pc_sel = pc_skip;
					end
				end
				op_ld_imm: begin
					// kk passes through the ALU
					alu_b = instr.xkk.kk;
					wr_x  = 1'b1;
				end
				op_add_imm: begin
					// No carry into VF for 7xkk
					alu_op = alu_add;
					alu_b  = instr.xkk.kk;
					wr_x   = 1'b1;
				end
				op_alu: begin
					wr_x = 1'b1;
					case (instr.xyn.n)
						4'h0: alu_op = alu_pass;
						4'h1: alu_op = alu_or;
						4'h2: alu_op = alu_and;
						4'h3: alu_op = alu_xor;
						4'h4: begin
							alu_op  = alu_add;
							flag_op = 1'b1;
						end
						4'h5: begin
							alu_op  = alu_sub;
							flag_op = 1'b1;
						end
						4'h6: begin
							alu_op  = alu_shr;
							flag_op = 1'b1;
						end
						4'h7: begin
							// SUBN, operands swapped
							alu_op  = alu_sub;
							alu_a   = regs.y_val;
							alu_b   = regs.x_val;
							flag_op = 1'b1;
						end
						4'hE: begin
							alu_op  = alu_shl;
							flag_op = 1'b1;
						end
						default: wr_x = 1'b0;
					endcase
				end
				op_jp_v0: begin
					// Low byte of V0 + nnn from the ALU, carry ripples into the top nibble
					regs.rd_x   = 4'h0;
					alu_op      = alu_add;
					alu_b       = instr.xkk.kk;
					pc_sel      = pc_jump;
					jump_target = {instr.nnn.addr[addr_w-1:word_w] + {3'b000, alu_flag}, alu_res};
				end
				default: pc_sel = pc_next;
			endcase
		end
	end

	assign regs.wr_x_en   = wr_x;
	assign regs.wr_x_data = alu_res;
	// VF port reports every change of VF, a plain write to VF included
	assign regs.wr_f_en   = flag_op | (wr_x & (instr.xyn.x == flag_reg));
	assign regs.wr_f_data = flag_op ? {{(word_w-1){1'b0}}, alu_flag} : alu_res;

endmodule

//--- verif/chip8_clk_gen.sv
// Testbench clock and power-on reset source, instantiated once by the CHIP-8 core testbench
`timescale 1ns/1ps
module chip8_clk_gen #(
	parameter int period_ns    = 20,
	parameter int reset_cycles = 2
) (
	output logic clk,
	output logic arst_n
);

	// Free-running clock, low for the first half period
	initial begin
		clk = 1'b0;
		forever begin
			#(period_ns / 2) clk = ~clk;
		end
	end

	// Reset held over the first rising edges, released away from any rising edge
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		arst_n <= 1'b1;
	end

endmodule

//--- verif/chip8_tb.sv
// Self-checking testbench running a random CHIP-8 program on the core against an ISA model
`timescale 1ns/1ps
module chip8_tb;
	import chip8_pkg::*;

	localparam int num_instr     = 3000;
	localparam int prelude_calls = 16;
	localparam int max_wait      = 5;
	localparam int clk_period    = 20;
	// Worst case per instruction is the wait states plus four cycles, doubled for margin
	localparam longint timeout_ns = longint'(num_instr + prelude_calls) *
		longint'(max_wait + 4) * longint'(clk_period) * 2;

	logic        clk;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	pc_t         wb_adr;
	logic [15:0] wb_dat_r;
	logic        wb_ack;
	logic        vx_we;
	reg_idx_t    vx_addr;
	byte_t       vx_data;
	logic        vf_we;
	byte_t       vf_data;

	// Byte-wide program memory and a table of ack delays, both filled from the seeded stream
	logic [7:0]  mem [4096];
	logic [2:0]  wait_tab [8192];

	// ISA model state
	byte_t       m_v [16];
	pc_t         m_pc;
	pc_t         m_stack [16];
	logic [3:0]  m_sp;

	// Responder and monitor state
	logic        next_ack;
	logic [15:0] next_dat;
	logic        req_active;
	logic [12:0] req_count;
	int          wait_left;
	int          since_ack;
	logic        started;
	int          exec_count;
	int          val_errors;
	int          proto_errors;

	chip8_clk_gen #(.period_ns(clk_period), .reset_cycles(2)) u_clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	chip8_core #(
		.start_addr  (start_addr),
		.stack_depth (stack_depth)
	) UUT (
		.cpu_clk  (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_adr   (wb_adr),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.vx_we    (vx_we),
		.vx_addr  (vx_addr),
		.vx_data  (vx_data),
		.vf_we    (vf_we),
		.vf_data  (vf_data)
	);

	task automatic check_pc(input pc_t exp);
		if (wb_adr !== exp) begin
			$display("Fail wb_adr expected %h actual %h", exp, wb_adr);
			val_errors++;
		end
	endtask

	task automatic check_reg(input reg_idx_t exp_addr, input byte_t exp_data);
		if (vx_addr !== exp_addr || vx_data !== exp_data) begin
			$display("Fail vx_addr/vx_data expected %h/%h actual %h/%h",
				exp_addr, exp_data, vx_addr, vx_data);
			val_errors++;
		end
	endtask

	task automatic check_flag(input byte_t exp);
		if (vf_data !== exp) begin
			$display("Fail vf_data expected %h actual %h", exp, vf_data);
			val_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			val_errors++;
		end
	endtask

	function automatic logic [15:0] read_word(input pc_t a);
		pc_t a_next;
		// Second byte wraps at the top of the address space
		a_next = a + 12'd1;
		return {mem[a], mem[a_next]};
	endfunction

	// One word from the kept set, weighted toward arithmetic
	function automatic logic [15:0] random_instr();
		int unsigned sel;
		reg_idx_t    x;
		reg_idx_t    y;
		byte_t       kk;
		pc_t         nnn;
		logic [3:0]  fn;
		sel = $urandom_range(0, 99);
		x   = 4'($urandom_range(0, 15));
		y   = 4'($urandom_range(0, 15));
		kk  = 8'($urandom);
		nnn = 12'($urandom);
		case ($urandom_range(0, 8))
			0: fn = 4'h0;
			1: fn = 4'h1;
			2: fn = 4'h2;
			3: fn = 4'h3;
			4: fn = 4'h4;
			5: fn = 4'h5;
			6: fn = 4'h6;
			7: fn = 4'h7;
			default: fn = 4'hE;
		endcase
		// Small constants make equal compares and taken skips likely
		if (sel < 6) return {4'h6, x, kk & 8'h03};
		else if (sel < 12) return {4'h6, x, kk};
		else if (sel < 22) return {4'h7, x, kk};
		else if (sel < 52) return {4'h8, x, y, fn};
		else if (sel < 58) return {4'h3, x, kk & 8'h03};
		else if (sel < 64) return {4'h4, x, kk & 8'h03};
		else if (sel < 68) return {4'h5, x, y, 4'h0};
		else if (sel < 72) return {4'h9, x, y, 4'h0};
		else if (sel < 76) return {4'h1, nnn};
		else if (sel < 80) return {4'h2, nnn};
		else if (sel < 85) return 16'h00EE;
		else if (sel < 88) return {4'hB, nnn};
		// No-op words from the dropped or unlisted encodings
		case ($urandom_range(0, 3))
			0: return (nnn == 12'h0EE) ? 16'h0000 : {4'h0, nnn};
			1: return {(($urandom_range(0, 1) != 0) ? 4'hA : 4'hC + 4'($urandom_range(0, 3))),
				nnn};
			2: return {4'h8, x, y, 4'h8 + 4'($urandom_range(0, 5))};
			default: return {4'h5, x, y, 4'h1 + 4'($urandom_range(0, 14))};
		endcase
	endfunction

	// Executes one word in the model and checks the EXEC-cycle write-back against it
	task automatic model_exec(input logic [15:0] w);
		reg_idx_t   x;
		reg_idx_t   y;
		logic [3:0] n;
		byte_t      kk;
		pc_t        nnn;
		pc_t        next_pc;
		logic       wr;
		logic       fl;
		logic       carry;
		logic [8:0] sum;
		byte_t      res;
		logic       e_vf_we;
		byte_t      e_vf_data;
		x       = w[11:8];
		y       = w[7:4];
		n       = w[3:0];
		kk      = w[7:0];
		nnn     = w[11:0];
		next_pc = m_pc + 12'd2;
		wr      = 1'b0;
		fl      = 1'b0;
		carry   = 1'b0;
		res     = 8'h00;
		case (w[15:12])
			4'h0: begin
				if (nnn == 12'h0EE) begin
					m_sp    = m_sp - 4'd1;
					next_pc = m_stack[m_sp];
				end
			end
			4'h1: next_pc = nnn;
			4'h2: begin
				m_stack[m_sp] = m_pc + 12'd2;
				m_sp          = m_sp + 4'd1;
				next_pc       = nnn;
			end
			4'h3: if (m_v[x] == kk) next_pc = m_pc + 12'd4;
			4'h4: if (m_v[x] != kk) next_pc = m_pc + 12'd4;
			4'h5: if (n == 4'h0 && m_v[x] == m_v[y]) next_pc = m_pc + 12'd4;
			4'h9: if (n == 4'h0 && m_v[x] != m_v[y]) next_pc = m_pc + 12'd4;
			4'h6: begin
				wr  = 1'b1;
				res = kk;
			end
			4'h7: begin
				wr  = 1'b1;
				res = m_v[x] + kk;
			end
			4'h8: begin
				wr = 1'b1;
				fl = 1'b1;
				case (n)
					4'h0: res = m_v[y];
					4'h1: res = m_v[x] | m_v[y];
					4'h2: res = m_v[x] & m_v[y];
					4'h3: res = m_v[x] ^ m_v[y];
					4'h4: begin
						sum   = {1'b0, m_v[x]} + {1'b0, m_v[y]};
						res   = sum[7:0];
						carry = sum[8];
					end
					4'h5: begin
						res   = m_v[x] - m_v[y];
						carry = (m_v[x] >= m_v[y]);
					end
					4'h6: begin
						res   = m_v[x] >> 1;
						carry = m_v[x][0];
					end
					4'h7: begin
						res   = m_v[y] - m_v[x];
						carry = (m_v[y] >= m_v[x]);
					end
					4'hE: begin
						res   = m_v[x] << 1;
						carry = m_v[x][7];
					end
					default: wr = 1'b0;
				endcase
				// Logic ops and moves leave VF alone
				if (n <= 4'h3 || !wr) fl = 1'b0;
			end
			4'hB: next_pc = nnn + pc_t'(m_v[0]);
			default: next_pc = m_pc + 12'd2;
		endcase
		// Flag result wins over a Vx write to VF
		e_vf_we   = fl | (wr & (x == 4'hF));
		e_vf_data = fl ? {7'b0, carry} : res;
		check_bit("vx_we", wr, vx_we);
		if (wr) check_reg(x, res);
		check_bit("vf_we", e_vf_we, vf_we);
		if (e_vf_we) check_flag(e_vf_data);
		if (wr) m_v[x] = res;
		if (e_vf_we) m_v[4'hF] = e_vf_data;
		m_pc = next_pc;
	endtask

	// Responder inputs change on the rising edge only
	always @(posedge clk) begin
		wb_ack   <= next_ack;
		wb_dat_r <= next_dat;
	end

	// Monitor and responder decisions, taken mid-cycle while outputs are settled
	always @(negedge clk) begin
		if (arst_n !== 1'b1) begin
			// The time-zero edge is only the clock leaving X
			if ($time > 0 && (wb_cyc !== 1'b0 || wb_stb !== 1'b0 ||
				vx_we !== 1'b0 || vf_we !== 1'b0)) begin
				$display("Protocol error: bus or write-back active while reset is asserted");
				proto_errors++;
			end
			next_ack = 1'b0;
		end else begin
			if (!started) begin
				started = 1'b1;
				if (wb_cyc !== 1'b1) begin
					$display("Protocol error: no fetch in the first cycle after reset");
					proto_errors++;
				end
			end
			if (since_ack >= 0) since_ack++;
			// EXEC is the one cycle after ack, the only place for write-back
			if (since_ack == 1) begin
				model_exec(read_word(m_pc));
				exec_count++;
				check_bit("wb_cyc", 1'b0, wb_cyc);
			end else if (vx_we !== 1'b0 || vf_we !== 1'b0) begin
				$display("Protocol error: write-back pulse outside the EXEC cycle");
				proto_errors++;
			end
			if (since_ack == 2 && wb_cyc !== 1'b1) begin
				$display("Protocol error: wb_cyc did not rise two cycles after ack");
				proto_errors++;
			end
			if (wb_cyc === 1'b1) begin
				if (!req_active) begin
					req_active = 1'b1;
					wait_left  = int'(wait_tab[req_count]);
					req_count  = req_count + 13'd1;
					since_ack  = -1;
				end
				// Strobe rides with the cycle for the whole request
				check_bit("wb_stb", 1'b1, wb_stb);
				// Address must match the model and hold until ack
				check_pc(m_pc);
				if (wb_ack === 1'b1) begin
					next_ack   = 1'b0;
					req_active = 1'b0;
					since_ack  = 0;
				end else if (wait_left == 0) begin
					next_ack = 1'b1;
					next_dat = read_word(wb_adr);
				end else begin
					wait_left--;
				end
			end else begin
				if (req_active) begin
					$display("Protocol error: wb_cyc dropped before ack");
					proto_errors++;
				end
				check_bit("wb_stb", 1'b0, wb_stb);
				next_ack = 1'b0;
			end
		end
	end

	initial begin
		int          i;
		logic [15:0] w;
		pc_t         a;
		void'($urandom(58972));
		wb_ack       = 1'b0;
		wb_dat_r     = 16'h0000;
		next_ack     = 1'b0;
		next_dat     = 16'h0000;
		req_active   = 1'b0;
		req_count    = 13'd0;
		wait_left    = 0;
		since_ack    = -1;
		started      = 1'b0;
		exec_count   = 0;
		val_errors   = 0;
		proto_errors = 0;
		m_pc         = start_addr;
		m_sp         = 4'd0;
		for (i = 0; i < 16; i++) begin
			m_v[i]     = 8'h00;
			m_stack[i] = 12'h000;
		end
		for (i = 0; i < 8192; i++) begin
			wait_tab[i] = 3'($urandom_range(0, max_wait));
		end
		for (i = 0; i < 4096; i += 2) begin
			w          = random_instr();
			mem[i]     = w[15:8];
			mem[i + 1] = w[7:0];
		end
		// Chain of calls fills every return slot before any RET can run
		for (i = 0; i < prelude_calls; i++) begin
			a                  = start_addr + pc_t'(2 * i);
			w                  = {4'h2, a + 12'd2};
			mem[a]             = w[15:8];
			mem[a + 12'd1]     = w[7:0];
		end
		wait (exec_count >= num_instr + prelude_calls);
		@(negedge clk);
		$display("Errors: %0d value, %0d protocol over %0d instructions",
			val_errors, proto_errors, exec_count);
		if (val_errors + proto_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog for a core that stops fetching
	initial begin
		#(timeout_ns);
		$display("Watchdog expired after %0d instructions", exec_count);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- verilog.f
common/chip8_pkg.sv
common/chip8_reg_if.sv
design/chip8_alu.sv
design/chip8_regfile.sv
design/chip8_pc_stack.sv
design/chip8_fetch.sv
design/control/chip8_control.sv
design/chip8_core.sv
verif/chip8_clk_gen.sv
verif/chip8_tb.sv
